/* list.f */
logic/mips_pkg.sv
logic/instr_decoder.sv
logic/operand_forward.sv
logic/branch_resolver.sv
logic/id_ex_reg.sv
logic/id_stage.sv
sim/id_stage_asserts.sv
sim/id_stage_tb.sv

/* sim/id_stage_tb.sv */
`timescale 1ns/1ps

module id_stage_tb;

	localparam int          CLK_PERIOD  = 8;
	localparam int          TEST_CYCLES = 8 + 22 + 7 + 5 + 24 + 12;    // reset plus all tests
	localparam logic [31:0] NOP         = 32'h0;

	logic clk, arst_n_i, mem_wreg_i, stall_o, branch_flag_o, wreg_o, in_delayslot_o;
	logic reg1_read_o, reg2_read_o;
	logic [4:0]  reg1_addr_o, reg2_addr_o, mem_wd_i, wd_o;
	logic [31:0] pc_i, inst_i, reg1_data_i, reg2_data_i, ex_wdata_i, mem_wdata_i;
	logic [31:0] branch_target_o, reg1_o, reg2_o, link_addr_o, inst_o;
	mips_pkg::alu_op_e  aluop_o;
	mips_pkg::alu_sel_e alusel_o;

	int          seed = 37;
	int          n_checks = 0;
	int          n_errors = 0;
	int          err_mark = 0;
	logic [31:0] pc_q;

	mips_pkg::funct_e fn_list [13] = '{mips_pkg::FN_AND, mips_pkg::FN_OR, mips_pkg::FN_XOR,
		mips_pkg::FN_NOR, mips_pkg::FN_ADD, mips_pkg::FN_ADDU, mips_pkg::FN_SUB,
		mips_pkg::FN_SUBU, mips_pkg::FN_SLT, mips_pkg::FN_SLTU, mips_pkg::FN_SLLV,
		mips_pkg::FN_SRLV, mips_pkg::FN_SRAV};
	mips_pkg::alu_op_e op_list [13] = '{mips_pkg::ALU_AND, mips_pkg::ALU_OR, mips_pkg::ALU_XOR,
		mips_pkg::ALU_NOR, mips_pkg::ALU_ADD, mips_pkg::ALU_ADDU, mips_pkg::ALU_SUB,
		mips_pkg::ALU_SUBU, mips_pkg::ALU_SLT, mips_pkg::ALU_SLTU, mips_pkg::ALU_SLL,
		mips_pkg::ALU_SRL, mips_pkg::ALU_SRA};

	id_stage DUT (.*);

	always #(CLK_PERIOD/2) clk = ~clk;

	// $n reads n in every byte
	function automatic logic [31:0] rf_value(input logic [4:0] n);
		return (n == 5'd0) ? 32'h0 : n * 32'h0101_0101;
	endfunction

	assign reg1_data_i = rf_value(reg1_addr_o);
	assign reg2_data_i = rf_value(reg2_addr_o);

	function automatic logic [31:0] r_type(input logic [4:0] rs, input logic [4:0] rt,
			input logic [4:0] rd, input logic [4:0] sa, input logic [5:0] fn);
		return {6'b000000, rs, rt, rd, sa, fn};
	endfunction

	function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic mips_pkg::alu_sel_e class_of(input int k);
		if (k < 4)
			return mips_pkg::SEL_LOGIC;
		else if (k < 10)
			return mips_pkg::SEL_ARITH;
		return mips_pkg::SEL_SHIFT;
	endfunction

	function automatic logic [31:0] branch_dest(input logic [31:0] pc, input logic [15:0] off);
		return pc + 32'd4 + {{14{off[15]}}, off, 2'b00};
	endfunction

	function automatic logic [31:0] jump_dest(input logic [31:0] pc, input logic [25:0] idx);
		logic [31:0] pc4;
		pc4 = pc + 32'd4;
		return {pc4[31:28], idx, 2'b00};
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		n_checks++;
		assert (got === exp) else begin
			$display("FAILED t=%0t %s: got %h, expected %h", $time, name, got, exp);
			n_errors++;
		end
	endtask

	task automatic drive(input logic [31:0] inst, input logic [31:0] pc, input logic mwreg,
			input logic [4:0] mwd, input logic [31:0] mwdata, input logic [31:0] exdata);
		@(posedge clk);
		inst_i      <= inst;
		pc_i        <= pc;
		mem_wreg_i  <= mwreg;
		mem_wd_i    <= mwd;
		mem_wdata_i <= mwdata;
		ex_wdata_i  <= exdata;
		@(negedge clk);    // combinational outputs settled here
	endtask

	task automatic send(input logic [31:0] inst);
		drive(inst, pc_q, 1'b0, 5'd0, 32'h0, 32'h0);
		pc_q = pc_q + 32'd4;
	endtask

	task automatic match_ex(input mips_pkg::alu_op_e op, input mips_pkg::alu_sel_e sel,
			input logic [4:0] wd, input logic [31:0] r1, input logic [31:0] r2);
		check_val("aluop_o", aluop_o, op);
		check_val("alusel_o", alusel_o, sel);
		check_val("wd_o", wd_o, wd);
		check_val("wreg_o", wreg_o, 1'b1);
		check_val("reg1_o", reg1_o, r1);
		check_val("reg2_o", reg2_o, r2);
	endtask

	task automatic decode_case(input logic [31:0] inst, input mips_pkg::alu_op_e op,
			input mips_pkg::alu_sel_e sel, input logic [4:0] wd, input logic [31:0] r1,
			input logic [31:0] r2);
		send(inst);
		send(NOP);
		match_ex(op, sel, wd, r1, r2);
		check_val("inst_o", inst_o, inst);
	endtask

	// branch or jump, then the delay slot, then one more to see the slot flag
	task automatic flow_case(input logic [31:0] inst, input logic [31:0] pc, input logic taken,
			input logic [31:0] target, input logic [31:0] link, input logic wreg,
			input logic [4:0] wd);
		pc_q = pc;
		send(inst);
		check_val("branch_flag_o", branch_flag_o, taken);
		if (taken)
			check_val("branch_target_o", branch_target_o, target);
		send(NOP);
		check_val("link_addr_o", link_addr_o, link);
		check_val("wreg_o", wreg_o, wreg);
		if (wreg)
			check_val("wd_o", wd_o, wd);
		send(NOP);
		check_val("in_delayslot_o", in_delayslot_o, taken);
	endtask

	task automatic report(input string name);
		if (n_errors == err_mark)
			$display("test %-10s ok", name);
		else
			$display("test %-10s %0d errors", name, n_errors - err_mark);
		err_mark = n_errors;
	endtask

	initial begin
		#((TEST_CYCLES + 40) * CLK_PERIOD);
		$display("timeout: tests did not finish in the expected time");
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		logic [4:0]  rs, rt, rd;
		logic [15:0] imm;
		logic [25:0] idx;
		logic [31:0] hold_pc;
		int          k;
		int          total;
		clk         = 1'b0;
		arst_n_i    = 1'b0;
		pc_i        = '0;
		inst_i      = '0;
		ex_wdata_i  = '0;
		mem_wreg_i  = 1'b0;
		mem_wd_i    = '0;
		mem_wdata_i = '0;
		pc_q        = 32'h0000_1000;
		repeat (8) @(posedge clk);
		arst_n_i <= 1'b1;

		repeat (6) begin
			k  = $unsigned($random(seed)) % 13;
			rs = 5'($random(seed));
			rt = 5'($random(seed));
			rd = 5'($random(seed));
			decode_case(r_type(rs, rt, rd, 5'd0, fn_list[k]), op_list[k], class_of(k), rd,
				rf_value(rs), rf_value(rt));
		end
		decode_case(r_type(5'd0, 5'd9, 5'd4, 5'd5, mips_pkg::FN_SLL), mips_pkg::ALU_SLL,
			mips_pkg::SEL_SHIFT, 5'd4, 32'd5, rf_value(9));
		rs  = 5'($random(seed));
		rt  = 5'($random(seed));
		imm = 16'($random(seed));
		decode_case(i_type(mips_pkg::OP_ORI, rs, rt, imm), mips_pkg::ALU_OR,
			mips_pkg::SEL_LOGIC, rt, rf_value(rs), {16'h0, imm});
		decode_case(i_type(mips_pkg::OP_ADDI, rs, rt, imm), mips_pkg::ALU_ADDI,
			mips_pkg::SEL_ARITH, rt, rf_value(rs), {{16{imm[15]}}, imm});
		decode_case(i_type(mips_pkg::OP_SLTIU, rs, rt, imm), mips_pkg::ALU_SLTU,
			mips_pkg::SEL_ARITH, rt, rf_value(rs), {{16{imm[15]}}, imm});
		decode_case(i_type(mips_pkg::OP_LUI, 5'd0, rt, imm), mips_pkg::ALU_OR,
			mips_pkg::SEL_LOGIC, rt, 32'h0, {imm, 16'h0});
		report("decode");

		drive(i_type(mips_pkg::OP_ORI, 5'd6, 5'd11, 16'h00f0), pc_q, 1'b1, 5'd6,
			32'hcafe_0001, 32'h0);
		send(NOP);
		match_ex(mips_pkg::ALU_OR, mips_pkg::SEL_LOGIC, 5'd11, 32'hcafe_0001, 32'h00f0);
		send(r_type(5'd1, 5'd2, 5'd5, 5'd0, mips_pkg::FN_ADDU));
		drive(r_type(5'd5, 5'd5, 5'd13, 5'd0, mips_pkg::FN_ADDU), pc_q, 1'b1, 5'd5,
			32'hbad0_0005, 32'h1234_5678);    // ex must win over mem
		send(NOP);
		match_ex(mips_pkg::ALU_ADDU, mips_pkg::SEL_ARITH, 5'd13, 32'h1234_5678, 32'h1234_5678);
		drive(i_type(mips_pkg::OP_ORI, 5'd0, 5'd14, 16'h0003), pc_q, 1'b1, 5'd0,
			32'hffff_ffff, 32'hffff_ffff);
		send(NOP);
		match_ex(mips_pkg::ALU_OR, mips_pkg::SEL_LOGIC, 5'd14, 32'h0, 32'h0003);
		report("forward");

		send(i_type(mips_pkg::OP_LW, 5'd2, 5'd7, 16'd4));
		hold_pc = pc_q;
		send(r_type(5'd7, 5'd3, 5'd9, 5'd0, mips_pkg::FN_ADDU));
		check_val("stall_o", stall_o, 1'b1);
		match_ex(mips_pkg::ALU_LW, mips_pkg::SEL_LOAD_STORE, 5'd7, rf_value(2), 32'd4);
		// load data now sits in mem
		drive(r_type(5'd7, 5'd3, 5'd9, 5'd0, mips_pkg::FN_ADDU), hold_pc, 1'b1, 5'd7,
			32'h0000_0077, 32'h0);
		check_val("stall_o", stall_o, 1'b0);
		check_val("aluop_o", aluop_o, mips_pkg::ALU_NOP);
		check_val("wreg_o", wreg_o, 1'b0);
		send(NOP);
		match_ex(mips_pkg::ALU_ADDU, mips_pkg::SEL_ARITH, 5'd9, 32'h0000_0077, rf_value(3));
		report("load_use");

		imm = 16'($random(seed));
		flow_case(i_type(mips_pkg::OP_BEQ, 5'd4, 5'd4, imm), 32'h0000_2000, 1'b1,
			branch_dest(32'h0000_2000, imm), 32'h0, 1'b0, 5'd0);
		flow_case(i_type(mips_pkg::OP_BEQ, 5'd4, 5'd5, imm), 32'h0000_2100, 1'b0,
			32'h0, 32'h0, 1'b0, 5'd0);
		imm = 16'($random(seed));
		flow_case(i_type(mips_pkg::OP_BNE, 5'd4, 5'd5, imm), 32'h0000_2200, 1'b1,
			branch_dest(32'h0000_2200, imm), 32'h0, 1'b0, 5'd0);
		flow_case(i_type(mips_pkg::OP_BNE, 5'd6, 5'd6, imm), 32'h0000_2300, 1'b0,
			32'h0, 32'h0, 1'b0, 5'd0);
		imm = 16'($random(seed));
		flow_case(i_type(mips_pkg::OP_BGTZ, 5'd3, 5'd0, imm), 32'h0000_2400, 1'b1,
			branch_dest(32'h0000_2400, imm), 32'h0, 1'b0, 5'd0);
		flow_case(i_type(mips_pkg::OP_BGTZ, 5'd0, 5'd0, imm), 32'h0000_2500, 1'b0,
			32'h0, 32'h0, 1'b0, 5'd0);
		imm = 16'($random(seed));
		flow_case(i_type(mips_pkg::OP_BLEZ, 5'd0, 5'd0, imm), 32'h0000_2600, 1'b1,
			branch_dest(32'h0000_2600, imm), 32'h0, 1'b0, 5'd0);
		flow_case(i_type(mips_pkg::OP_BLEZ, 5'd3, 5'd0, imm), 32'h0000_2700, 1'b0,
			32'h0, 32'h0, 1'b0, 5'd0);
		report("branch");

		idx = 26'($random(seed));
		flow_case({mips_pkg::OP_J, idx}, 32'h4000_0100, 1'b1, jump_dest(32'h4000_0100, idx),
			32'h0, 1'b0, 5'd0);
		flow_case({mips_pkg::OP_JAL, idx}, 32'h5000_0200, 1'b1, jump_dest(32'h5000_0200, idx),
			32'h5000_0208, 1'b1, 5'd31);
		flow_case(r_type(5'd8, 5'd0, 5'd0, 5'd0, mips_pkg::FN_JR), 32'h0000_3000, 1'b1,
			rf_value(8), 32'h0, 1'b0, 5'd0);
		flow_case(r_type(5'd12, 5'd0, 5'd10, 5'd0, mips_pkg::FN_JALR), 32'h0000_3100, 1'b1,
			rf_value(12), 32'h0000_3108, 1'b1, 5'd10);
		report("jump");

		total = n_errors + DUT.u_asserts.fail_cnt;
		$display("%0d checks, %0d errors, %0d assertion failures", n_checks, n_errors,
			DUT.u_asserts.fail_cnt);
		if (total == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

/* sim/id_stage_asserts.sv */
`timescale 1ns/1ps

module id_stage_asserts (
	input logic                            clk,
	input logic                            arst_n_i,
	input logic                            stall_i,
	input logic                            branch_flag_i,
	input mips_pkg::alu_op_e               aluop_i,
	input mips_pkg::alu_sel_e              alusel_i,
	input logic [mips_pkg::REG_ADDR_W-1:0] wd_i,
	input logic                            wreg_i,
	input logic                            in_delayslot_i
);

	int   fail_cnt   = 0;
	logic in_reset_d = 1'b0;    // reset seen at the previous edge
	logic last_flag;            // branch flag of last accepted instr

	always @(posedge clk) begin
		in_reset_d <= !arst_n_i;
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i)
			last_flag <= 1'b0;
		else if (!stall_i)
			last_flag <= branch_flag_i;
	end

	reset_values: assert property (@(posedge clk) (!arst_n_i && in_reset_d) |->
		aluop_i == mips_pkg::ALU_NOP && alusel_i == mips_pkg::SEL_NOP && !wreg_i &&
		!in_delayslot_i && !stall_i && !branch_flag_i)
	else begin
		$error("control outputs not cleared while reset is held");
		fail_cnt++;
	end

	bubble_after_stall: assert property (@(posedge clk) disable iff (!arst_n_i)
		stall_i |=> aluop_i == mips_pkg::ALU_NOP && alusel_i == mips_pkg::SEL_NOP &&
		!wreg_i && wd_i == '0 && $stable(in_delayslot_i))
	else begin
		$error("stall cycle was not followed by a bubble");
		fail_cnt++;
	end

	delay_slot_follows: assert property (@(posedge clk) disable iff (!arst_n_i)
		!stall_i |=> in_delayslot_i == $past(last_flag))
	else begin
		$error("in_delayslot_o does not match branch flag of previous instruction");
		fail_cnt++;
	end

	jal_links_r31: assert property (@(posedge clk) disable iff (!arst_n_i)
		aluop_i == mips_pkg::ALU_JAL |-> wreg_i && wd_i == 5'd31)
	else begin
		$error("jal does not write the link register");
		fail_cnt++;
	end

endmodule

bind id_stage id_stage_asserts u_asserts (
	.clk(clk), .arst_n_i(arst_n_i), .stall_i(stall_o), .branch_flag_i(branch_flag_o),
	.aluop_i(aluop_o), .alusel_i(alusel_o), .wd_i(wd_o), .wreg_i(wreg_o),
	.in_delayslot_i(in_delayslot_o)
);

/* logic/id_stage.sv */
`timescale 1ns/1ps

module id_stage (
	input  logic                             clk,
	input  logic                             arst_n_i,
	input  logic [mips_pkg::WORD_W-1:0]      pc_i,
	input  logic [mips_pkg::WORD_W-1:0]      inst_i,
	input  logic [mips_pkg::WORD_W-1:0]      reg1_data_i,
	input  logic [mips_pkg::WORD_W-1:0]      reg2_data_i,
	input  logic [mips_pkg::WORD_W-1:0]      ex_wdata_i,
	input  logic                             mem_wreg_i,
	input  logic [mips_pkg::REG_ADDR_W-1:0]  mem_wd_i,
	input  logic [mips_pkg::WORD_W-1:0]      mem_wdata_i,
	output logic                             reg1_read_o,
	output logic                             reg2_read_o,
	output logic [mips_pkg::REG_ADDR_W-1:0]  reg1_addr_o,
	output logic [mips_pkg::REG_ADDR_W-1:0]  reg2_addr_o,
	output logic                             stall_o,
	output logic                             branch_flag_o,
	output logic [mips_pkg::WORD_W-1:0]      branch_target_o,
	output mips_pkg::alu_op_e                aluop_o,
	output mips_pkg::alu_sel_e               alusel_o,
	output logic [mips_pkg::WORD_W-1:0]      reg1_o,
	output logic [mips_pkg::WORD_W-1:0]      reg2_o,
	output logic [mips_pkg::REG_ADDR_W-1:0]  wd_o,
	output logic                             wreg_o,
	output logic [mips_pkg::WORD_W-1:0]      link_addr_o,
	output logic [mips_pkg::WORD_W-1:0]      inst_o,
	output logic                             in_delayslot_o
);

	mips_pkg::alu_op_e               dec_alu_op;
	mips_pkg::alu_sel_e              dec_alu_sel;
	mips_pkg::branch_e               dec_br_kind;
	logic [mips_pkg::REG_ADDR_W-1:0] dec_wd;
	logic                            dec_wreg;
	logic [mips_pkg::WORD_W-1:0]     dec_imm;
	logic [mips_pkg::WORD_W-1:0]     opnd1;
	logic [mips_pkg::WORD_W-1:0]     opnd2;
	logic [mips_pkg::WORD_W-1:0]     link_addr;

	instr_decoder u_dec (
		.arst_n_i, .inst_i,
		.alu_op_o(dec_alu_op), .alu_sel_o(dec_alu_sel), .wd_o(dec_wd), .wreg_o(dec_wreg),
		.reg1_read_o, .reg2_read_o, .reg1_addr_o, .reg2_addr_o,
		.imm_o(dec_imm), .br_kind_o(dec_br_kind)
	);

	// ex side comes from our own id/ex register
	operand_forward u_fwd1 (
		.read_i(reg1_read_o), .addr_i(reg1_addr_o),
		.ex_wreg_i(wreg_o), .ex_wd_i(wd_o), .ex_wdata_i,
		.mem_wreg_i, .mem_wd_i, .mem_wdata_i,
		.rf_data_i(reg1_data_i), .imm_i(dec_imm), .operand_o(opnd1)
	);

	operand_forward u_fwd2 (
		.read_i(reg2_read_o), .addr_i(reg2_addr_o),
		.ex_wreg_i(wreg_o), .ex_wd_i(wd_o), .ex_wdata_i,
		.mem_wreg_i, .mem_wd_i, .mem_wdata_i,
		.rf_data_i(reg2_data_i), .imm_i(dec_imm), .operand_o(opnd2)
	);

	branch_resolver u_br (
		.arst_n_i, .pc_i, .inst_i, .br_kind_i(dec_br_kind),
		.reg1_i(opnd1), .reg2_i(opnd2),
		.branch_flag_o, .branch_target_o, .link_addr_o(link_addr)
	);

	id_ex_reg u_idex (
		.clk, .arst_n_i,
		.alu_op_i(dec_alu_op), .alu_sel_i(dec_alu_sel), .wd_i(dec_wd), .wreg_i(dec_wreg),
		.reg1_i(opnd1), .reg2_i(opnd2), .link_addr_i(link_addr), .inst_i,
		.branch_flag_i(branch_flag_o),
		.reg1_read_i(reg1_read_o), .reg2_read_i(reg2_read_o),
		.reg1_addr_i(reg1_addr_o), .reg2_addr_i(reg2_addr_o),
		.stall_o, .aluop_o, .alusel_o, .reg1_o, .reg2_o, .wd_o, .wreg_o,
		.link_addr_o, .inst_o, .in_delayslot_o
	);

endmodule

/* logic/id_ex_reg.sv */
`timescale 1ns/1ps

module id_ex_reg (
	input  logic                             clk,
	input  logic                             arst_n_i,
	input  mips_pkg::alu_op_e                alu_op_i,
	input  mips_pkg::alu_sel_e               alu_sel_i,
	input  logic [mips_pkg::REG_ADDR_W-1:0]  wd_i,
	input  logic                             wreg_i,
	input  logic [mips_pkg::WORD_W-1:0]      reg1_i,
	input  logic [mips_pkg::WORD_W-1:0]      reg2_i,
	input  logic [mips_pkg::WORD_W-1:0]      link_addr_i,
	input  logic [mips_pkg::WORD_W-1:0]      inst_i,
	input  logic                             branch_flag_i,
	input  logic                             reg1_read_i,
	input  logic                             reg2_read_i,
	input  logic [mips_pkg::REG_ADDR_W-1:0]  reg1_addr_i,
	input  logic [mips_pkg::REG_ADDR_W-1:0]  reg2_addr_i,
	output logic                             stall_o,
	output mips_pkg::alu_op_e                aluop_o,
	output mips_pkg::alu_sel_e               alusel_o,
	output logic [mips_pkg::WORD_W-1:0]      reg1_o,
	output logic [mips_pkg::WORD_W-1:0]      reg2_o,
	output logic [mips_pkg::REG_ADDR_W-1:0]  wd_o,
	output logic                             wreg_o,
	output logic [mips_pkg::WORD_W-1:0]      link_addr_o,
	output logic [mips_pkg::WORD_W-1:0]      inst_o,
	output logic                             in_delayslot_o
);

	logic ds_pending;    // next accepted instr is a delay slot
	logic use1;
	logic use2;

	// load result not ready until mem, so a dependent read must wait a cycle
	assign use1    = reg1_read_i && (reg1_addr_i == wd_o) && (reg1_addr_i != mips_pkg::NOP_REG);
	assign use2    = reg2_read_i && (reg2_addr_i == wd_o) && (reg2_addr_i != mips_pkg::NOP_REG);
	assign stall_o = (aluop_o == mips_pkg::ALU_LW) && (use1 || use2);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			aluop_o        <= mips_pkg::ALU_NOP;
			alusel_o       <= mips_pkg::SEL_NOP;
			reg1_o         <= '0;
			reg2_o         <= '0;
			wd_o           <= mips_pkg::NOP_REG;
			wreg_o         <= 1'b0;
			link_addr_o    <= '0;
			inst_o         <= '0;
			in_delayslot_o <= 1'b0;
			ds_pending     <= 1'b0;
		end else if (stall_o) begin
			aluop_o     <= mips_pkg::ALU_NOP;    // bubble, ds flags held
			alusel_o    <= mips_pkg::SEL_NOP;
			reg1_o      <= '0;
			reg2_o      <= '0;
			wd_o        <= mips_pkg::NOP_REG;
			wreg_o      <= 1'b0;
			link_addr_o <= '0;
			inst_o      <= '0;
		end else begin
			aluop_o        <= alu_op_i;
			alusel_o       <= alu_sel_i;
			reg1_o         <= reg1_i;
			reg2_o         <= reg2_i;
			wd_o           <= wd_i;
			wreg_o         <= wreg_i;
			link_addr_o    <= link_addr_i;
			inst_o         <= inst_i;
			in_delayslot_o <= ds_pending;
			ds_pending     <= branch_flag_i;
		end
	end

endmodule

/* logic/branch_resolver.sv */
`timescale 1ns/1ps

module branch_resolver (
	input  logic                         arst_n_i,
	input  logic [mips_pkg::WORD_W-1:0]  pc_i,
	input  logic [mips_pkg::WORD_W-1:0]  inst_i,
	input  mips_pkg::branch_e            br_kind_i,
	input  logic [mips_pkg::WORD_W-1:0]  reg1_i,
	input  logic [mips_pkg::WORD_W-1:0]  reg2_i,
	output logic                         branch_flag_o,
	output logic [mips_pkg::WORD_W-1:0]  branch_target_o,
	output logic [mips_pkg::WORD_W-1:0]  link_addr_o
);

	logic [mips_pkg::WORD_W-1:0] pc_plus_4;
	logic [mips_pkg::WORD_W-1:0] pc_plus_8;
	logic [mips_pkg::WORD_W-1:0] rel_target;
	logic [mips_pkg::WORD_W-1:0] abs_target;
	logic                        cond;

	assign pc_plus_4  = pc_i + 32'd4;
	assign pc_plus_8  = pc_i + 32'd8;    // return past the delay slot
	assign rel_target = pc_plus_4 + {{14{inst_i[15]}}, inst_i[15:0], 2'b00};
	assign abs_target = {pc_plus_4[31:28], inst_i[25:0], 2'b00};

	always_comb begin
		case (br_kind_i)
			mips_pkg::BR_BEQ:  cond = (reg1_i == reg2_i);
			mips_pkg::BR_BNE:  cond = (reg1_i != reg2_i);
			mips_pkg::BR_BGTZ: cond = !reg1_i[31] && (reg1_i != '0);
			mips_pkg::BR_BLEZ: cond = reg1_i[31] || (reg1_i == '0);
			default:           cond = 1'b0;
		endcase
	end

	always_comb begin
		branch_flag_o   = 1'b0;
		branch_target_o = '0;
		link_addr_o     = '0;
		if (arst_n_i) begin
			case (br_kind_i)
				mips_pkg::BR_J, mips_pkg::BR_JAL: begin
					branch_flag_o   = 1'b1;
					branch_target_o = abs_target;
				end
				mips_pkg::BR_JR, mips_pkg::BR_JALR: begin
					branch_flag_o   = 1'b1;
					branch_target_o = reg1_i;
				end
				default: begin
					branch_flag_o   = cond;
					branch_target_o = cond ? rel_target : '0;
				end
			endcase
			if (br_kind_i == mips_pkg::BR_JAL || br_kind_i == mips_pkg::BR_JALR)
				link_addr_o = pc_plus_8;
		end
	end

endmodule

/* logic/operand_forward.sv */
`timescale 1ns/1ps

module operand_forward (
	input  logic                             read_i,
	input  logic [mips_pkg::REG_ADDR_W-1:0]  addr_i,
	input  logic                             ex_wreg_i,
	input  logic [mips_pkg::REG_ADDR_W-1:0]  ex_wd_i,
	input  logic [mips_pkg::WORD_W-1:0]      ex_wdata_i,
	input  logic                             mem_wreg_i,
	input  logic [mips_pkg::REG_ADDR_W-1:0]  mem_wd_i,
	input  logic [mips_pkg::WORD_W-1:0]      mem_wdata_i,
	input  logic [mips_pkg::WORD_W-1:0]      rf_data_i,
	input  logic [mips_pkg::WORD_W-1:0]      imm_i,
	output logic [mips_pkg::WORD_W-1:0]      operand_o
);

	logic addr_live;
	logic ex_hit;
	logic mem_hit;

	assign addr_live = read_i && (addr_i != mips_pkg::NOP_REG);    // $0 never forwarded
	assign ex_hit    = addr_live && ex_wreg_i && (ex_wd_i == addr_i);
	assign mem_hit   = addr_live && mem_wreg_i && (mem_wd_i == addr_i);

	// youngest result wins
	always_comb begin
		if (!read_i)
			operand_o = imm_i;
		else if (ex_hit)
			operand_o = ex_wdata_i;
		else if (mem_hit)
			operand_o = mem_wdata_i;
		else
			operand_o = rf_data_i;
	end

endmodule

/* logic/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
	input  logic                             arst_n_i,
	input  logic [mips_pkg::WORD_W-1:0]      inst_i,
	output mips_pkg::alu_op_e                alu_op_o,
	output mips_pkg::alu_sel_e               alu_sel_o,
	output logic [mips_pkg::REG_ADDR_W-1:0]  wd_o,
	output logic                             wreg_o,
	output logic                             reg1_read_o,
	output logic                             reg2_read_o,
	output logic [mips_pkg::REG_ADDR_W-1:0]  reg1_addr_o,
	output logic [mips_pkg::REG_ADDR_W-1:0]  reg2_addr_o,
	output logic [mips_pkg::WORD_W-1:0]      imm_o,
	output mips_pkg::branch_e                br_kind_o
);

	mips_pkg::opcode_e op;
	mips_pkg::funct_e  fn;
	logic [mips_pkg::WORD_W-1:0] imm_zext;
	logic [mips_pkg::WORD_W-1:0] imm_sext;

	function automatic mips_pkg::alu_op_e funct_alu(input mips_pkg::funct_e f);
		case (f)
			mips_pkg::FN_AND:  return mips_pkg::ALU_AND;
			mips_pkg::FN_OR:   return mips_pkg::ALU_OR;
			mips_pkg::FN_XOR:  return mips_pkg::ALU_XOR;
			mips_pkg::FN_NOR:  return mips_pkg::ALU_NOR;
			mips_pkg::FN_SLL:  return mips_pkg::ALU_SLL;
			mips_pkg::FN_SLLV: return mips_pkg::ALU_SLL;
			mips_pkg::FN_SRL:  return mips_pkg::ALU_SRL;
			mips_pkg::FN_SRLV: return mips_pkg::ALU_SRL;
			mips_pkg::FN_SRA:  return mips_pkg::ALU_SRA;
			mips_pkg::FN_SRAV: return mips_pkg::ALU_SRA;
			mips_pkg::FN_ADD:  return mips_pkg::ALU_ADD;
			mips_pkg::FN_ADDU: return mips_pkg::ALU_ADDU;
			mips_pkg::FN_SUB:  return mips_pkg::ALU_SUB;
			mips_pkg::FN_SUBU: return mips_pkg::ALU_SUBU;
			mips_pkg::FN_SLT:  return mips_pkg::ALU_SLT;
			mips_pkg::FN_SLTU: return mips_pkg::ALU_SLTU;
			mips_pkg::FN_JR:   return mips_pkg::ALU_JR;
			mips_pkg::FN_JALR: return mips_pkg::ALU_JALR;
			default:           return mips_pkg::ALU_NOP;
		endcase
	endfunction

	function automatic mips_pkg::alu_op_e opcode_alu(input mips_pkg::opcode_e o);
		case (o)
			mips_pkg::OP_ORI:   return mips_pkg::ALU_OR;
			mips_pkg::OP_LUI:   return mips_pkg::ALU_OR;    // rs | imm<<16
			mips_pkg::OP_ANDI:  return mips_pkg::ALU_AND;
			mips_pkg::OP_XORI:  return mips_pkg::ALU_XOR;
			mips_pkg::OP_ADDI:  return mips_pkg::ALU_ADDI;
			mips_pkg::OP_ADDIU: return mips_pkg::ALU_ADDIU;
			mips_pkg::OP_SLTI:  return mips_pkg::ALU_SLT;
			mips_pkg::OP_SLTIU: return mips_pkg::ALU_SLTU;
			mips_pkg::OP_LW:    return mips_pkg::ALU_LW;
			mips_pkg::OP_SW:    return mips_pkg::ALU_SW;
			mips_pkg::OP_J:     return mips_pkg::ALU_J;
			mips_pkg::OP_JAL:   return mips_pkg::ALU_JAL;
			mips_pkg::OP_BEQ:   return mips_pkg::ALU_BEQ;
			mips_pkg::OP_BNE:   return mips_pkg::ALU_BNE;
			mips_pkg::OP_BGTZ:  return mips_pkg::ALU_BGTZ;
			mips_pkg::OP_BLEZ:  return mips_pkg::ALU_BLEZ;
			default:            return mips_pkg::ALU_NOP;
		endcase
	endfunction

	assign op       = mips_pkg::opcode_e'(inst_i[31:26]);
	assign fn       = mips_pkg::funct_e'(inst_i[5:0]);
	assign imm_zext = {16'h0, inst_i[15:0]};
	assign imm_sext = {{16{inst_i[15]}}, inst_i[15:0]};

	always_comb begin
		alu_op_o    = mips_pkg::ALU_NOP;
		alu_sel_o   = mips_pkg::SEL_NOP;
		wd_o        = inst_i[15:11];    // rd
		wreg_o      = 1'b0;
		reg1_read_o = 1'b0;
		reg2_read_o = 1'b0;
		reg1_addr_o = inst_i[25:21];    // rs
		reg2_addr_o = inst_i[20:16];    // rt
		imm_o       = '0;
		br_kind_o   = mips_pkg::BR_NONE;
		if (arst_n_i) begin
			case (op)
				mips_pkg::OP_SPECIAL: begin
					wreg_o      = 1'b1;
					reg1_read_o = 1'b1;
					reg2_read_o = 1'b1;
					alu_op_o    = funct_alu(fn);
					case (fn)
						mips_pkg::FN_AND, mips_pkg::FN_OR, mips_pkg::FN_XOR,
						mips_pkg::FN_NOR: alu_sel_o = mips_pkg::SEL_LOGIC;
						mips_pkg::FN_SLL, mips_pkg::FN_SRL, mips_pkg::FN_SRA: begin
							alu_sel_o   = mips_pkg::SEL_SHIFT;
							reg1_read_o = 1'b0;    // shamt replaces rs
							imm_o       = {27'd0, inst_i[10:6]};
						end
						mips_pkg::FN_SLLV, mips_pkg::FN_SRLV,
						mips_pkg::FN_SRAV: alu_sel_o = mips_pkg::SEL_SHIFT;
						mips_pkg::FN_ADD, mips_pkg::FN_ADDU, mips_pkg::FN_SUB,
						mips_pkg::FN_SUBU, mips_pkg::FN_SLT,
						mips_pkg::FN_SLTU: alu_sel_o = mips_pkg::SEL_ARITH;
						mips_pkg::FN_JR, mips_pkg::FN_JALR: begin
							alu_sel_o   = mips_pkg::SEL_JUMP_BRANCH;
							reg2_read_o = 1'b0;
							wreg_o      = (fn == mips_pkg::FN_JALR);    // link into rd
							br_kind_o   = (fn == mips_pkg::FN_JALR) ?
								mips_pkg::BR_JALR : mips_pkg::BR_JR;
						end
						default: begin
							wreg_o      = 1'b0;
							reg1_read_o = 1'b0;
							reg2_read_o = 1'b0;
						end
					endcase
				end
				mips_pkg::OP_ORI, mips_pkg::OP_ANDI, mips_pkg::OP_XORI, mips_pkg::OP_LUI,
				mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU,
				mips_pkg::OP_LW: begin
					wreg_o      = 1'b1;
					reg1_read_o = 1'b1;
					wd_o        = inst_i[20:16];    // rt
					alu_op_o    = opcode_alu(op);
					imm_o       = imm_sext;
					if (op == mips_pkg::OP_LW)
						alu_sel_o = mips_pkg::SEL_LOAD_STORE;
					else if (op == mips_pkg::OP_LUI) begin
						alu_sel_o = mips_pkg::SEL_LOGIC;
						imm_o     = {inst_i[15:0], 16'h0};
					end
					else if (op == mips_pkg::OP_ORI || op == mips_pkg::OP_ANDI ||
						op == mips_pkg::OP_XORI) begin
						alu_sel_o = mips_pkg::SEL_LOGIC;
						imm_o     = imm_zext;
					end
					else
						alu_sel_o = mips_pkg::SEL_ARITH;
				end
				mips_pkg::OP_SW: begin
					alu_op_o    = mips_pkg::ALU_SW;
					alu_sel_o   = mips_pkg::SEL_LOAD_STORE;
					reg1_read_o = 1'b1;
					reg2_read_o = 1'b1;    // store data
				end
				mips_pkg::OP_J, mips_pkg::OP_JAL: begin
					alu_op_o  = opcode_alu(op);
					alu_sel_o = mips_pkg::SEL_JUMP_BRANCH;
					wreg_o    = (op == mips_pkg::OP_JAL);
					wd_o      = mips_pkg::LINK_REG;
					br_kind_o = (op == mips_pkg::OP_JAL) ? mips_pkg::BR_JAL : mips_pkg::BR_J;
				end
				mips_pkg::OP_BEQ, mips_pkg::OP_BNE, mips_pkg::OP_BGTZ, mips_pkg::OP_BLEZ: begin
					alu_op_o    = opcode_alu(op);
					alu_sel_o   = mips_pkg::SEL_JUMP_BRANCH;
					reg1_read_o = 1'b1;
					reg2_read_o = (op == mips_pkg::OP_BEQ) || (op == mips_pkg::OP_BNE);
					case (op)
						mips_pkg::OP_BEQ:  br_kind_o = mips_pkg::BR_BEQ;
						mips_pkg::OP_BNE:  br_kind_o = mips_pkg::BR_BNE;
						mips_pkg::OP_BGTZ: br_kind_o = mips_pkg::BR_BGTZ;
						default:           br_kind_o = mips_pkg::BR_BLEZ;
					endcase
				end
				default: ;    // unknown, stays a nop
			endcase
		end
	end

endmodule

/* logic/mips_pkg.sv */
package mips_pkg;

	localparam int WORD_W     = 32;
	localparam int REG_ADDR_W = 5;

	localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31;    // written by jal
	localparam logic [REG_ADDR_W-1:0] NOP_REG  = 5'd0;

	// primary opcode, inst[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'b000000,
		OP_J       = 6'b000010,
		OP_JAL     = 6'b000011,
		OP_BEQ     = 6'b000100,
		OP_BNE     = 6'b000101,
		OP_BLEZ    = 6'b000110,
		OP_BGTZ    = 6'b000111,
		OP_ADDI    = 6'b001000,
		OP_ADDIU   = 6'b001001,
		OP_SLTI    = 6'b001010,
		OP_SLTIU   = 6'b001011,
		OP_ANDI    = 6'b001100,
		OP_ORI     = 6'b001101,
		OP_XORI    = 6'b001110,
		OP_LUI     = 6'b001111,
		OP_LW      = 6'b100011,
		OP_SW      = 6'b101011
	} opcode_e;

	// special function field, inst[5:0]
	typedef enum logic [5:0] {
		FN_SLL  = 6'b000000,
		FN_SRL  = 6'b000010,
		FN_SRA  = 6'b000011,
		FN_SLLV = 6'b000100,
		FN_SRLV = 6'b000110,
		FN_SRAV = 6'b000111,
		FN_JR   = 6'b001000,
		FN_JALR = 6'b001001,
		FN_ADD  = 6'b100000,
		FN_ADDU = 6'b100001,
		FN_SUB  = 6'b100010,
		FN_SUBU = 6'b100011,
		FN_AND  = 6'b100100,
		FN_OR   = 6'b100101,
		FN_XOR  = 6'b100110,
		FN_NOR  = 6'b100111,
		FN_SLT  = 6'b101010,
		FN_SLTU = 6'b101011
	} funct_e;

	typedef enum logic [7:0] {
		ALU_NOP   = 8'b00000000,
		ALU_OR    = 8'b00100101,
		ALU_AND   = 8'b00100100,
		ALU_XOR   = 8'b00100110,
		ALU_NOR   = 8'b00100111,
		ALU_SLL   = 8'b01111100,
		ALU_SRL   = 8'b00000010,
		ALU_SRA   = 8'b00000011,
		ALU_ADD   = 8'b00100000,
		ALU_ADDU  = 8'b00100001,
		ALU_ADDI  = 8'b01010101,
		ALU_ADDIU = 8'b01010110,
		ALU_SUB   = 8'b00100010,
		ALU_SUBU  = 8'b00100011,
		ALU_SLT   = 8'b00101010,
		ALU_SLTU  = 8'b00101011,
		ALU_LW    = 8'b11100011,
		ALU_SW    = 8'b11101011,
		ALU_J     = 8'b01001111,
		ALU_JAL   = 8'b01010000,
		ALU_JR    = 8'b00001000,
		ALU_JALR  = 8'b00001001,
		ALU_BEQ   = 8'b01010001,
		ALU_BNE   = 8'b01010010,
		ALU_BGTZ  = 8'b01010100,
		ALU_BLEZ  = 8'b01010011
	} alu_op_e;

	typedef enum logic [2:0] {
		SEL_NOP         = 3'b000,
		SEL_LOGIC       = 3'b001,
		SEL_SHIFT       = 3'b010,
		SEL_ARITH       = 3'b100,
		SEL_JUMP_BRANCH = 3'b110,
		SEL_LOAD_STORE  = 3'b111
	} alu_sel_e;

	typedef enum logic [3:0] {
		BR_NONE, BR_BEQ, BR_BNE, BR_BGTZ, BR_BLEZ, BR_J, BR_JAL, BR_JR, BR_JALR
	} branch_e;

endpackage
